/* all.f */
+incdir+logic
logic/core_pkg.sv
logic/ctrl_if.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/execute_unit.sv
logic/instruction_memory.sv
logic/data_memory.sv
logic/core.sv
sim/core_assertions.sv
sim/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module core_tb -f all.f -o core_tb_sim

./obj_dir/core_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

/* sim/core_tb.sv */
`timescale 1ns/100ps
`include "core_cfg.svh"

module core_tb;
  import core_pkg::*;

  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 160;
  localparam int WATCHDOG_NS = NUM_TESTS * TEST_CYCLES * 40 + 4000;
  localparam int RUN_LIMIT   = 100;
  localparam int IM_AW       = $clog2(`CORE_IMEM_WORDS);
  localparam int DM_AW       = $clog2(`CORE_DMEM_WORDS);

  logic      clk;
  logic      reset;
  logic      imem_we;
  word_t     imem_addr;
  word_t     imem_wdata;
  word_t     pc;
  reg_addr_t dbg_rsel;
  word_t     dbg_rdata;

  // Instruction-set model state.
  word_t m_pc;
  word_t m_regs [32];
  word_t m_dmem [`CORE_DMEM_WORDS];
  word_t m_imem [`CORE_IMEM_WORDS];

  word_t prog [$];
  int    seed = 32'haa25;
  int    err_count = 0;
  int    err_mark = 0;
  int    failed_tests = 0;
  logic  cmp_en = 1'b0;

  core dut (.*);

  bind core core_assertions u_assertions (.*);

  always #20 clk = ~clk;

  function automatic word_t r_type(int f3, int f7, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OP};
  endfunction

  function automatic word_t i_type(logic [6:0] opc, int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic word_t s_type(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OPC_STORE};
  endfunction

  function automatic word_t b_type(int f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], `OPC_BRANCH};
  endfunction

  function automatic word_t u_type(logic [6:0] opc, int rd, int imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic word_t j_type(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OPC_JAL};
  endfunction

  function automatic void reset_model();
    m_pc = `CORE_RESET_PC;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
  endfunction

  // Retires one instruction in the model.
  function automatic void step_model();
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      ea;
    word_t      wv;
    word_t      next_pc;
    logic       wr;
    logic       take;
    logic [2:0] f3;
    ins = m_imem[m_pc[IM_AW+1:2]];
    f3 = ins[14:12];
    a = m_regs[ins[19:15]];
    b = m_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    wr = 1'b0;
    wv = '0;
    take = 1'b0;
    next_pc = m_pc + 32'd4;
    case (ins[6:0])
      `OPC_OP: begin
        wr = 1'b1;
        case (f3)
          3'b000: wv = ins[30] ? a - b : a + b;
          3'b001: wv = a << b[4:0];
          3'b010: wv = {31'b0, $signed(a) < $signed(b)};
          3'b100: wv = a ^ b;
          3'b101: begin
            wv = a >> b[4:0];
            wr = !ins[30];
          end
          3'b110: wv = a | b;
          3'b111: wv = a & b;
          default: wr = 1'b0;
        endcase
      end
      `OPC_OP_IMM: begin
        wr = (f3 == 3'b000);
        wv = a + imm_i;
      end
      `OPC_LUI: begin
        wr = 1'b1;
        wv = {ins[31:12], 12'b0};
      end
      `OPC_AUIPC: begin
        wr = 1'b1;
        wv = m_pc + {ins[31:12], 12'b0};
      end
      `OPC_LOAD: begin
        ea = a + imm_i;
        wr = (f3 == 3'b010);
        wv = m_dmem[ea[DM_AW+1:2]];
      end
      `OPC_STORE: begin
        ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        if (f3 == 3'b010) begin
          m_dmem[ea[DM_AW+1:2]] = b;
        end
      end
      `OPC_BRANCH: begin
        case (f3)
          3'b000: take = (a == b);
          3'b001: take = (a != b);
          3'b100: take = ($signed(a) < $signed(b));
          3'b101: take = ($signed(a) >= $signed(b));
          default: take = 1'b0;
        endcase
        if (take) begin
          next_pc = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      `OPC_JAL: begin
        wr = 1'b1;
        wv = m_pc + 32'd4;
        next_pc = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      default: ;
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      m_regs[ins[11:7]] = wv;
    end
    m_pc = next_pc;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      reset_model();
    end else begin
      step_model();
    end
  end

  always @(negedge clk) begin
    if (cmp_en && pc !== m_pc) begin
      err_count++;
      $display("ERR %0t: pc is %h, model expects %h", $time, pc, m_pc);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  // Program goes in while reset is held.
  task automatic load_program();
    cmp_en = 1'b0;
    reset = 1'b1;
    for (int i = 0; i < prog.size(); i++) begin
      @(negedge clk);
      imem_we = 1'b1;
      imem_addr = 32'(i * 4);
      imem_wdata = prog[i];
      m_imem[i] = prog[i];
    end
    @(negedge clk);
    imem_we = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    cmp_en = 1'b1;
  endtask

  task automatic run_to(input word_t target);
    int n;
    n = 0;
    while (pc !== target && n < RUN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (pc !== target) begin
      err_count++;
      $display("Program never reached pc %h within %0d cycles", target, RUN_LIMIT);
    end
  endtask

  task automatic check_regs();
    @(negedge clk);
    dbg_rsel = '0;
    for (int r = 0; r < 32; r++) begin
      @(negedge clk);
      if (dbg_rdata !== m_regs[r]) begin
        err_count++;
        $display("ERR %0t: x%0d is %h, model expects %h", $time, r, dbg_rdata, m_regs[r]);
      end
      dbg_rsel = 5'(r + 1);
    end
  endtask

  task automatic end_test(input string name);
    if (err_count == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, err_count - err_mark);
    end
    err_mark = err_count;
  endtask

  // Last word of each program is a jump to itself.
  task automatic run_program(input string name);
    load_program();
    run_to(32'(4 * (prog.size() - 1)));
    check_regs();
    end_test(name);
  endtask

  initial begin
    word_t rv;
    clk = 1'b0;
    reset = 1'b1;
    imem_we = 1'b0;
    imem_addr = '0;
    imem_wdata = '0;
    dbg_rsel = '0;
    reset_model();

    prog = {};
    for (int r = 1; r <= 8; r++) begin
      rv = $random(seed);
      prog.push_back(u_type(`OPC_LUI, r, rv >> 12));
      prog.push_back(i_type(`OPC_OP_IMM, 0, r, r, rv));
    end
    prog.push_back(r_type(0, 0, 10, 1, 2));
    prog.push_back(r_type(0, 32, 11, 3, 4));
    prog.push_back(r_type(7, 0, 12, 5, 6));
    prog.push_back(r_type(6, 0, 13, 7, 8));
    prog.push_back(r_type(4, 0, 14, 1, 3));
    prog.push_back(r_type(2, 0, 15, 2, 4));
    prog.push_back(r_type(2, 0, 16, 4, 2));
    prog.push_back(r_type(1, 0, 17, 5, 6));
    prog.push_back(r_type(5, 0, 18, 7, 8));
    prog.push_back(j_type(0, 0));
    run_program("alu");

    prog = {};
    rv = $random(seed);
    prog.push_back(u_type(`OPC_LUI, 1, rv >> 12));
    prog.push_back(u_type(`OPC_AUIPC, 2, rv));
    prog.push_back(u_type(`OPC_AUIPC, 3, 0));
    prog.push_back(u_type(`OPC_AUIPC, 4, 32'hfffff));
    prog.push_back(u_type(`OPC_LUI, 5, 32'h80000));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 6, 5, -1));
    prog.push_back(j_type(0, 0));
    run_program("lui_auipc");

    // Base register 0x80, offsets on both sides.
    prog = {};
    prog.push_back(i_type(`OPC_OP_IMM, 0, 1, 0, 128));
    for (int r = 2; r <= 3; r++) begin
      rv = $random(seed);
      prog.push_back(u_type(`OPC_LUI, r, rv >> 12));
      prog.push_back(i_type(`OPC_OP_IMM, 0, r, r, rv));
    end
    prog.push_back(s_type(2, 1, 8));
    prog.push_back(s_type(3, 1, -12));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 4, 1, 16));
    prog.push_back(s_type(3, 4, -4));
    prog.push_back(i_type(`OPC_LOAD, 2, 5, 1, 8));
    prog.push_back(i_type(`OPC_LOAD, 2, 6, 1, -12));
    prog.push_back(i_type(`OPC_LOAD, 2, 7, 4, -8));
    prog.push_back(i_type(`OPC_LOAD, 2, 8, 1, 12));
    prog.push_back(j_type(0, 0));
    run_program("load_store");

    prog = {};
    prog.push_back(i_type(`OPC_OP_IMM, 0, 1, 0, -5));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 2, 0, 3));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 3, 0, 3));
    prog.push_back(b_type(0, 2, 3, 8));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 10, 0, 1));
    prog.push_back(b_type(1, 2, 3, 8));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 11, 0, 2));
    prog.push_back(b_type(4, 1, 2, 8));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 12, 0, 3));
    prog.push_back(b_type(5, 1, 2, 8));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 13, 0, 4));
    prog.push_back(b_type(5, 2, 1, 8));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 14, 0, 5));
    prog.push_back(b_type(4, 2, 1, 8));
    prog.push_back(b_type(5, 2, 3, 8));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 15, 0, 6));
    prog.push_back(b_type(0, 1, 2, 8));
    // Backward branch loop, three passes.
    prog.push_back(i_type(`OPC_OP_IMM, 0, 5, 0, 3));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 5, 5, -1));
    prog.push_back(b_type(1, 5, 0, -4));
    prog.push_back(j_type(0, 0));
    run_program("branch");

    prog = {};
    prog.push_back(j_type(1, 12));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 10, 0, 1));
    prog.push_back(j_type(0, 12));
    prog.push_back(j_type(5, -8));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 11, 0, 2));
    prog.push_back(j_type(0, 0));
    run_program("jal");

    prog = {};
    prog.push_back(i_type(`OPC_OP_IMM, 0, 1, 0, 5));
    prog.push_back(32'hffff_ffff);
    prog.push_back(i_type(`OPC_OP_IMM, 0, 2, 1, 1));
    prog.push_back(i_type(`OPC_OP_IMM, 0, 3, 0, -7));
    prog.push_back(j_type(0, 0));
    load_program();
    run_to(32'd16);
    check_regs();
    @(negedge clk);
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    run_to(32'd8);
    // Reset again partway through the program.
    reset = 1'b1;
    repeat (2) @(negedge clk);
    if (pc !== `CORE_RESET_PC) begin
      err_count++;
      $display("ERR %0t: pc is %h during reset, expected %h", $time, pc, `CORE_RESET_PC);
    end
    check_regs();
    reset = 1'b0;
    run_to(32'd16);
    check_regs();
    end_test("reset_unknown_op");

    if (dut.u_assertions.fail_count != 0) begin
      $display("Assertions failed %0d times", dut.u_assertions.fail_count);
      err_count += dut.u_assertions.fail_count;
    end
    $display("tests: %0d, failed tests: %0d, errors: %0d", NUM_TESTS, failed_tests, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* sim/core_assertions.sv */
`timescale 1ns/100ps

module core_assertions (
  input logic                clk,
  input logic                reset,
  input core_pkg::word_t     pc,
  input core_pkg::word_t     instruction,
  input core_pkg::word_t     rs1_data,
  input core_pkg::reg_addr_t dbg_rsel,
  input core_pkg::word_t     dbg_rdata,
  input logic                rf_wen,
  input logic                dm_wen
);

  int fail_count = 0;

  // x0 reads zero on the decode port and on the debug port.
  rs1_x0_zero: assert property (@(posedge clk)
      (instruction[19:15] == 5'd0) |-> (rs1_data == 32'd0))
    else begin
      fail_count++;
      $error("x0 read as nonzero through rs1");
    end

  dbg_x0_zero: assert property (@(posedge clk)
      (dbg_rsel == 5'd0) |-> (dbg_rdata == 32'd0))
    else begin
      fail_count++;
      $error("x0 read as nonzero through the debug port");
    end

  no_write_in_reset: assert property (@(posedge clk) reset |-> !(rf_wen || dm_wen))
    else begin
      fail_count++;
      $error("Register or memory write enabled during reset");
    end

  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("PC is not word-aligned");
    end

endmodule

/* logic/core.sv */
`timescale 1ns/100ps
`include "core_cfg.svh"

module core (
  input  logic                clk,
  input  logic                reset,
  input  logic                imem_we,
  input  core_pkg::word_t     imem_addr,
  input  core_pkg::word_t     imem_wdata,
  output core_pkg::word_t     pc,
  input  core_pkg::reg_addr_t dbg_rsel,
  output core_pkg::word_t     dbg_rdata
);
  import core_pkg::*;

  word_t instruction;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_a;
  word_t alu_b;
  word_t exec_result;
  word_t mem_rdata;
  word_t wb_data;
  word_t pc_plus4;
  word_t pc_next;
  logic  branch_taken;
  logic  rf_wen;
  logic  dm_wen;

  ctrl_if ctrl ();

  instruction_memory u_imem (
    .clk   (clk),
    .we    (imem_we),
    .waddr (imem_addr),
    .wdata (imem_wdata),
    .raddr (pc),
    .rdata (instruction)
  );

  instr_decoder u_decoder (
    .instruction (instruction),
    .ctrl        (ctrl)
  );

  // No architectural writes while reset is held.
  assign rf_wen = ctrl.reg_wen & ~reset;
  assign dm_wen = ctrl.mem_wen & ~reset;

  register_file u_regs (
    .clk       (clk),
    .reset     (reset),
    .rsel1     (ctrl.rs1),
    .rsel2     (ctrl.rs2),
    .wsel      (ctrl.rd),
    .dbg_rsel  (dbg_rsel),
    .wen       (rf_wen),
    .wdata     (wb_data),
    .rdata1    (rs1_data),
    .rdata2    (rs2_data),
    .dbg_rdata (dbg_rdata)
  );

  assign alu_a = ctrl.op1_pc ? pc : rs1_data;
  assign alu_b = ctrl.op2_imm ? ctrl.imm : rs2_data;

  execute_unit u_exec (
    .a            (alu_a),
    .b            (alu_b),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .alu_op       (ctrl.alu_op),
    .branch_cond  (ctrl.branch_cond),
    .result       (exec_result),
    .branch_taken (branch_taken)
  );

  data_memory u_dmem (
    .clk   (clk),
    .wen   (dm_wen),
    .addr  (exec_result),
    .wdata (rs2_data),
    .rdata (mem_rdata)
  );

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  wb_data = mem_rdata;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = exec_result;
    endcase
  end

  // Jump and branch targets come out of the execute unit.
  assign pc_next = (ctrl.jump || branch_taken) ? exec_result : pc_plus4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `CORE_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

/* logic/data_memory.sv */
`timescale 1ns/100ps
`include "core_cfg.svh"

module data_memory (
  input  logic            clk,
  input  logic            wen,
  input  core_pkg::word_t addr,
  input  core_pkg::word_t wdata,
  output core_pkg::word_t rdata
);
  import core_pkg::*;

  localparam int AW = $clog2(`CORE_DMEM_WORDS);

  word_t             mem [`CORE_DMEM_WORDS];
  logic [AW-1:0]     index;

  // Word index, byte offset dropped.
  assign index = addr[AW+1:2];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[index] <= wdata;
    end
  end

  assign rdata = mem[index];

endmodule

/* logic/instruction_memory.sv */
`timescale 1ns/100ps
`include "core_cfg.svh"

module instruction_memory (
  input  logic            clk,
  input  logic            we,
  input  core_pkg::word_t waddr,
  input  core_pkg::word_t wdata,
  input  core_pkg::word_t raddr,
  output core_pkg::word_t rdata
);
  import core_pkg::*;

  localparam int AW = $clog2(`CORE_IMEM_WORDS);

  word_t mem [`CORE_IMEM_WORDS];

  // Load port for the program image.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr[AW+1:2]] <= wdata;
    end
  end

  assign rdata = mem[raddr[AW+1:2]];

endmodule

/* logic/execute_unit.sv */
`timescale 1ns/100ps

module execute_unit (
  input  core_pkg::word_t        a,
  input  core_pkg::word_t        b,
  input  core_pkg::word_t        rs1_data,
  input  core_pkg::word_t        rs2_data,
  input  core_pkg::alu_op_t      alu_op,
  input  core_pkg::branch_cond_t branch_cond,
  output core_pkg::word_t        result,
  output logic                   branch_taken
);
  import core_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLL:    result = a << shamt;
      ALU_SRL:    result = a >> shamt;
      ALU_PASS_B: result = b;
      default:    result = a + b;
    endcase
  end

  // Branch compare works on register values, not on the ALU operands.
  always_comb begin
    case (branch_cond)
      BR_EQ:   branch_taken = (rs1_data == rs2_data);
      BR_NE:   branch_taken = (rs1_data != rs2_data);
      BR_LT:   branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      BR_GE:   branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

/* logic/register_file.sv */
`timescale 1ns/100ps

module register_file (
  input  logic               clk,
  input  logic               reset,
  input  core_pkg::reg_addr_t rsel1,
  input  core_pkg::reg_addr_t rsel2,
  input  core_pkg::reg_addr_t wsel,
  input  core_pkg::reg_addr_t dbg_rsel,
  input  logic               wen,
  input  core_pkg::word_t    wdata,
  output core_pkg::word_t    rdata1,
  output core_pkg::word_t    rdata2,
  output core_pkg::word_t    dbg_rdata
);
  import core_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != 5'd0) begin
      regs[wsel] <= wdata;
    end
  end

  // Register 0 is hardwired to zero.
  assign rdata1    = (rsel1 == 5'd0) ? '0 : regs[rsel1];
  assign rdata2    = (rsel2 == 5'd0) ? '0 : regs[rsel2];
  assign dbg_rdata = (dbg_rsel == 5'd0) ? '0 : regs[dbg_rsel];

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/100ps
`include "core_cfg.svh"

module instr_decoder (
  input core_pkg::word_t instruction,
  ctrl_if.decoder        ctrl
);
  import core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];

  assign ctrl.rs1 = instruction[19:15];
  assign ctrl.rs2 = instruction[24:20];
  assign ctrl.rd  = instruction[11:7];

  always_comb begin
    ctrl.reg_wen     = 1'b0;
    ctrl.mem_wen     = 1'b0;
    ctrl.alu_op      = ALU_ADD;
    ctrl.op1_pc      = 1'b0;
    ctrl.op2_imm     = 1'b0;
    ctrl.wb_sel      = WB_ALU;
    ctrl.branch_cond = BR_NONE;
    ctrl.jump        = 1'b0;
    ctrl.imm         = '0;
    case (opcode)
      `OPC_OP: begin
        ctrl.reg_wen = 1'b1;
        case (funct3)
          3'b000: ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
          3'b111: ctrl.alu_op = ALU_AND;
          3'b110: ctrl.alu_op = ALU_OR;
          3'b100: ctrl.alu_op = ALU_XOR;
          3'b010: ctrl.alu_op = ALU_SLT;
          3'b001: ctrl.alu_op = ALU_SLL;
          3'b101: begin
            // SRA is outside the subset.
            ctrl.alu_op  = ALU_SRL;
            ctrl.reg_wen = ~funct7[5];
          end
          default: ctrl.reg_wen = 1'b0;
        endcase
      end
      `OPC_OP_IMM: begin
        ctrl.reg_wen = (funct3 == 3'b000);
        ctrl.op2_imm = 1'b1;
        ctrl.imm     = {{20{instruction[31]}}, instruction[31:20]};
      end
      `OPC_LUI: begin
        ctrl.reg_wen = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.alu_op  = ALU_PASS_B;
        ctrl.imm     = {instruction[31:12], 12'b0};
      end
      `OPC_AUIPC: begin
        ctrl.reg_wen = 1'b1;
        ctrl.op1_pc  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.imm     = {instruction[31:12], 12'b0};
      end
      `OPC_LOAD: begin
        ctrl.reg_wen = (funct3 == 3'b010);
        ctrl.op2_imm = 1'b1;
        ctrl.wb_sel  = WB_MEM;
        ctrl.imm     = {{20{instruction[31]}}, instruction[31:20]};
      end
      `OPC_STORE: begin
        ctrl.mem_wen = (funct3 == 3'b010);
        ctrl.op2_imm = 1'b1;
        ctrl.imm     = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
      end
      `OPC_BRANCH: begin
        ctrl.op1_pc  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.imm     = {{19{instruction[31]}}, instruction[31], instruction[7],
                        instruction[30:25], instruction[11:8], 1'b0};
        case (funct3)
          3'b000:  ctrl.branch_cond = BR_EQ;
          3'b001:  ctrl.branch_cond = BR_NE;
          3'b100:  ctrl.branch_cond = BR_LT;
          3'b101:  ctrl.branch_cond = BR_GE;
          default: ctrl.branch_cond = BR_NONE;
        endcase
      end
      `OPC_JAL: begin
        ctrl.reg_wen = 1'b1;
        ctrl.op1_pc  = 1'b1;
        ctrl.op2_imm = 1'b1;
        ctrl.jump    = 1'b1;
        ctrl.wb_sel  = WB_PC4;
        ctrl.imm     = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                        instruction[20], instruction[30:21], 1'b0};
      end
      default: ;
    endcase
  end

endmodule

/* logic/ctrl_if.sv */
`timescale 1ns/100ps

interface ctrl_if;
  import core_pkg::*;

  reg_addr_t    rs1;
  reg_addr_t    rs2;
  reg_addr_t    rd;
  logic         reg_wen;
  logic         mem_wen;
  alu_op_t      alu_op;
  logic         op1_pc;
  logic         op2_imm;
  wb_sel_t      wb_sel;
  branch_cond_t branch_cond;
  logic         jump;
  word_t        imm;

  modport decoder (
    output rs1, rs2, rd, reg_wen, mem_wen, alu_op, op1_pc, op2_imm,
           wb_sel, branch_cond, jump, imm
  );

  modport datapath (
    input rs1, rs2, rd, reg_wen, mem_wen, alu_op, op1_pc, op2_imm,
          wb_sel, branch_cond, jump, imm
  );

endinterface

/* logic/core_pkg.sv */
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLL    = 4'd6,
    ALU_SRL    = 4'd7,
    ALU_PASS_B = 4'd8
  } alu_op_t;

  // Source of the register write-back value.
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2
  } wb_sel_t;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_EQ   = 3'd1,
    BR_NE   = 3'd2,
    BR_LT   = 3'd3,
    BR_GE   = 3'd4
  } branch_cond_t;

endpackage

/* logic/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_RESET_PC   32'h0000_0000
`define CORE_IMEM_WORDS 64
`define CORE_DMEM_WORDS 64

`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111

`endif
